// ==== hdl/cx_macros.svh ====
// Compute complex sizes and address map

`ifndef CX_MACROS_SVH
`define CX_MACROS_SVH

`define CX_DATA_W        32
`define CX_REGS          16
`define CX_N_CONSTANTS   4
`define CX_PROG_DEPTH    16
`define CX_N_SLOTS       4
`define CX_START_DELAY   2

// Region select is the top two bits of the 8-bit configuration address
`define CX_CONST_BASE    2'd0
`define CX_PROG_BASE     2'd1
`define CX_MOVER_BASE    2'd2

`endif

// ==== hdl/cx_pkg.sv ====
// Compute complex shared types

`default_nettype none

`include "cx_macros.svh"

package cx_pkg;

    typedef logic [`CX_DATA_W-1:0] word_t;
    typedef logic [$clog2(`CX_REGS)-1:0] reg_idx_t;

    // Instruction word is 16 bits: opcode [15:12], rd [11:8], ra [7:4], rb [3:0]
    // MOV copies ra into rd and ignores rb
    typedef enum logic [3:0] {
        OP_STOP = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_MUL  = 4'd3,
        OP_MOV  = 4'd4
    } cx_opcode_e;

    typedef enum logic {CORE_IDLE, CORE_RUN} core_state_e;

    typedef enum logic [1:0] {MOVE_IDLE, MOVE_READ, MOVE_DONE} mover_state_e;

endpackage

`default_nettype wire

// ==== hdl/cx_write_if.sv ====
// Register write stream

`timescale 1ns/1ps
`default_nettype none

interface cx_write_if import cx_pkg::*; ();

    logic     valid;
    reg_idx_t idx;
    word_t    data;
    logic     last;

    modport source (output valid, output idx, output data, output last);

    modport sink (input valid, input idx, input data, input last);

    // The register file has no use for framing
    modport core_sink (input valid, input idx, input data);

endinterface

`default_nettype wire

// ==== hdl/constant_injector.sv ====
// Constant injector

`timescale 1ns/1ps
`default_nettype none

`include "cx_macros.svh"

module constant_injector import cx_pkg::*; (
    input  wire logic       core_clock,
    input  wire logic       rst_n,
    input  wire logic       cfg_wr,
    input  wire logic [7:0] cfg_addr,
    input  wire word_t      cfg_data,
    input  wire logic       start,
    cx_write_if.source      wr,
    output logic            seq_done
);

    localparam int CW = $clog2(`CX_N_CONSTANTS);
    localparam int NW = $clog2(`CX_N_CONSTANTS + 1);

    word_t          const_mem [`CX_N_CONSTANTS];
    logic [NW-1:0]  n_active;
    logic [CW-1:0]  beat;
    logic           busy;
    logic           cfg_hit;

    assign cfg_hit = cfg_wr && (cfg_addr[7:6] == `CX_CONST_BASE);

    always_ff @(posedge core_clock) begin
        if (cfg_hit && cfg_addr[5:0] < `CX_N_CONSTANTS) begin
            const_mem[cfg_addr[CW-1:0]] <= cfg_data;
        end
    end

    // Constant k always lands in register k
    assign wr.idx  = reg_idx_t'(beat);
    assign wr.data = const_mem[beat];

    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            n_active <= '0;
            busy     <= 1'b0;
            beat     <= '0;
            wr.valid <= 1'b0;
            wr.last  <= 1'b0;
            seq_done <= 1'b0;
        end else begin
            seq_done <= 1'b0;
            wr.valid <= 1'b0;
            wr.last  <= 1'b0;
            if (cfg_hit && cfg_addr[5:0] == 6'h3F) begin
                // Counts above the slot count are clamped
                if (cfg_data > `CX_N_CONSTANTS)
                    n_active <= NW'(`CX_N_CONSTANTS);
                else
                    n_active <= cfg_data[NW-1:0];
            end
            if (busy) begin
                if (wr.last) begin
                    busy     <= 1'b0;
                    seq_done <= 1'b1;
                end else begin
                    beat     <= beat + 1'b1;
                    wr.valid <= 1'b1;
                    wr.last  <= ({1'b0, beat} + NW'(2)) == n_active;
                end
            end else if (start) begin
                if (n_active == '0) begin
                    seq_done <= 1'b1;
                end else begin
                    busy     <= 1'b1;
                    beat     <= '0;
                    wr.valid <= 1'b1;
                    wr.last  <= (n_active == NW'(1));
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/write_merger.sv ====
// Write merger and run sequencer

`timescale 1ns/1ps
`default_nettype none

`include "cx_macros.svh"

module write_merger import cx_pkg::*; (
    input  wire logic     core_clock,
    input  wire logic     rst_n,
    input  wire logic     in_valid,
    input  wire reg_idx_t in_idx,
    input  wire word_t    in_data,
    input  wire logic     seq_done,
    cx_write_if.sink      const_wr,
    cx_write_if.source    core_wr,
    output logic          run
);

    localparam int DW = $clog2(`CX_START_DELAY + 1);

    logic          hold_valid;
    reg_idx_t      hold_idx;
    word_t         hold_data;
    logic [DW-1:0] delay_cnt;

    // Constant beats have priority, an outside beat that loses waits in the hold
    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            hold_valid    <= 1'b0;
            core_wr.valid <= 1'b0;
            core_wr.last  <= 1'b0;
        end else begin
            core_wr.valid <= const_wr.valid || hold_valid || in_valid;
            core_wr.last  <= const_wr.valid && const_wr.last;
            if (const_wr.valid) begin
                core_wr.idx  <= const_wr.idx;
                core_wr.data <= const_wr.data;
                if (in_valid) begin
                    hold_valid <= 1'b1;
                    hold_idx   <= in_idx;
                    hold_data  <= in_data;
                end
            end else if (hold_valid) begin
                core_wr.idx  <= hold_idx;
                core_wr.data <= hold_data;
                hold_valid   <= in_valid;
                hold_idx     <= in_idx;
                hold_data    <= in_data;
            end else begin
                core_wr.idx  <= in_idx;
                core_wr.data <= in_data;
            end
        end
    end

    // Loaded on seq_done, run fires as the count reaches one
    always_ff @(posedge core_clock) begin
        if (!rst_n)
            delay_cnt <= '0;
        else if (seq_done)
            delay_cnt <= DW'(`CX_START_DELAY);
        else if (delay_cnt != '0)
            delay_cnt <= delay_cnt - 1'b1;
    end

    assign run = (delay_cnt == DW'(1));

endmodule

`default_nettype wire

// ==== hdl/program_core.sv ====
// Program core

`timescale 1ns/1ps
`default_nettype none

`include "cx_macros.svh"

module program_core import cx_pkg::*; (
    input  wire logic       core_clock,
    input  wire logic       rst_n,
    input  wire logic       cfg_wr,
    input  wire logic [7:0] cfg_addr,
    input  wire word_t      cfg_data,
    input  wire logic       run,
    input  wire reg_idx_t   rd_idx,
    cx_write_if.core_sink   wr,
    output word_t           rd_data,
    output logic            core_done
);

    localparam int PW = $clog2(`CX_PROG_DEPTH);

    word_t         rf [`CX_REGS];
    logic [15:0]   instr_mem [`CX_PROG_DEPTH];
    core_state_e   state;
    logic [PW-1:0] pc;
    logic [15:0]   instr;
    cx_opcode_e    opcode;
    reg_idx_t      op_rd;
    reg_idx_t      op_ra;
    reg_idx_t      op_rb;
    word_t         exec_result;
    logic          exec_we;

    assign instr  = instr_mem[pc];
    assign opcode = cx_opcode_e'(instr[15:12]);
    assign op_rd  = instr[11:8];
    assign op_ra  = instr[7:4];
    assign op_rb  = instr[3:0];

    always_ff @(posedge core_clock) begin
        if (cfg_wr && cfg_addr[7:6] == `CX_PROG_BASE && cfg_addr[5:0] < `CX_PROG_DEPTH) begin
            instr_mem[cfg_addr[PW-1:0]] <= cfg_data[15:0];
        end
    end

    // Arithmetic wraps at the word width, MUL keeps the low word
    always_comb begin
        exec_result = '0;
        exec_we     = 1'b0;
        if (state == CORE_RUN) begin
            case (opcode)
                OP_ADD: begin
                    exec_result = rf[op_ra] + rf[op_rb];
                    exec_we     = 1'b1;
                end
                OP_SUB: begin
                    exec_result = rf[op_ra] - rf[op_rb];
                    exec_we     = 1'b1;
                end
                OP_MUL: begin
                    exec_result = rf[op_ra] * rf[op_rb];
                    exec_we     = 1'b1;
                end
                OP_MOV: begin
                    exec_result = rf[op_ra];
                    exec_we     = 1'b1;
                end
                default: begin
                    exec_we = 1'b0;
                end
            endcase
        end
    end

    // The executing instruction is written last so it wins a collision
    always_ff @(posedge core_clock) begin
        if (wr.valid)
            rf[wr.idx] <= wr.data;
        if (exec_we)
            rf[op_rd] <= exec_result;
        rd_data <= rf[rd_idx];
    end

    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            state     <= CORE_IDLE;
            pc        <= '0;
            core_done <= 1'b0;
        end else begin
            core_done <= 1'b0;
            case (state)
                CORE_IDLE: begin
                    if (run) begin
                        state <= CORE_RUN;
                        pc    <= '0;
                    end
                end
                CORE_RUN: begin
                    if (opcode == OP_STOP || pc == PW'(`CX_PROG_DEPTH - 1)) begin
                        state     <= CORE_IDLE;
                        core_done <= 1'b1;
                    end else begin
                        pc <= pc + 1'b1;
                    end
                end
                default: state <= CORE_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/result_mover.sv ====
// Result mover

`timescale 1ns/1ps
`default_nettype none

`include "cx_macros.svh"

module result_mover import cx_pkg::*; (
    input  wire logic                           core_clock,
    input  wire logic                           rst_n,
    input  wire logic                           cfg_wr,
    input  wire logic [7:0]                     cfg_addr,
    input  wire word_t                          cfg_data,
    input  wire logic                           core_done,
    input  wire word_t                          rd_data,
    output reg_idx_t                            rd_idx,
    output logic                                out_valid,
    output logic [$clog2(`CX_N_SLOTS)-1:0]      out_slot,
    output word_t                               out_data,
    output logic                                out_last,
    output logic                                done
);

    localparam int SW = $clog2(`CX_N_SLOTS);
    localparam int NW = $clog2(`CX_N_SLOTS + 1);

    reg_idx_t      slot_reg [`CX_N_SLOTS];
    logic [NW-1:0] n_slots;
    logic [SW-1:0] rd_cnt;
    mover_state_e  state;
    logic          cfg_hit;

    assign cfg_hit = cfg_wr && (cfg_addr[7:6] == `CX_MOVER_BASE);

    always_ff @(posedge core_clock) begin
        if (cfg_hit && cfg_addr[5:0] < `CX_N_SLOTS)
            slot_reg[cfg_addr[SW-1:0]] <= cfg_data[$bits(reg_idx_t)-1:0];
    end

    // A read issued in MOVE_READ returns on the next cycle with its beat
    assign rd_idx   = slot_reg[rd_cnt];
    assign out_data = rd_data;

    always_ff @(posedge core_clock) begin
        if (!rst_n) begin
            n_slots   <= '0;
            rd_cnt    <= '0;
            state     <= MOVE_IDLE;
            out_valid <= 1'b0;
            out_slot  <= '0;
            out_last  <= 1'b0;
            done      <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            done      <= 1'b0;
            if (cfg_hit && cfg_addr[5:0] == 6'h3F) begin
                if (cfg_data > `CX_N_SLOTS)
                    n_slots <= NW'(`CX_N_SLOTS);
                else
                    n_slots <= cfg_data[NW-1:0];
            end
            case (state)
                MOVE_IDLE: begin
                    rd_cnt <= '0;
                    if (core_done)
                        state <= (n_slots == '0) ? MOVE_DONE : MOVE_READ;
                end
                MOVE_READ: begin
                    out_valid <= 1'b1;
                    out_slot  <= rd_cnt;
                    out_last  <= ({1'b0, rd_cnt} == n_slots - 1'b1);
                    if ({1'b0, rd_cnt} == n_slots - 1'b1)
                        state <= MOVE_DONE;
                    else
                        rd_cnt <= rd_cnt + 1'b1;
                end
                MOVE_DONE: begin
                    done  <= 1'b1;
                    state <= MOVE_IDLE;
                end
                default: state <= MOVE_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/core_complex.sv ====
// Compute complex top level

`timescale 1ns/1ps
`default_nettype none

`include "cx_macros.svh"

module core_complex import cx_pkg::*; (
    input  wire logic                           core_clock,
    input  wire logic                           rst_n,
    input  wire logic                           cfg_wr,
    input  wire logic [7:0]                     cfg_addr,
    input  wire word_t                          cfg_data,
    input  wire logic                           start,
    input  wire logic                           in_valid,
    input  wire reg_idx_t                       in_idx,
    input  wire word_t                          in_data,
    output logic                                out_valid,
    output logic [$clog2(`CX_N_SLOTS)-1:0]      out_slot,
    output word_t                               out_data,
    output logic                                out_last,
    output logic                                done
);

    cx_write_if const_wr_if ();
    cx_write_if core_wr_if ();

    logic     seq_done;
    logic     run;
    logic     core_done;
    reg_idx_t rd_idx;
    word_t    rd_data;

    constant_injector u_injector (
        .core_clock (core_clock),
        .rst_n      (rst_n),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .start      (start),
        .wr         (const_wr_if.source),
        .seq_done   (seq_done)
    );

    write_merger u_merger (
        .core_clock (core_clock),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_idx     (in_idx),
        .in_data    (in_data),
        .seq_done   (seq_done),
        .const_wr   (const_wr_if.sink),
        .core_wr    (core_wr_if.source),
        .run        (run)
    );

    program_core u_core (
        .core_clock (core_clock),
        .rst_n      (rst_n),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .run        (run),
        .rd_idx     (rd_idx),
        .wr         (core_wr_if.core_sink),
        .rd_data    (rd_data),
        .core_done  (core_done)
    );

    result_mover u_mover (
        .core_clock (core_clock),
        .rst_n      (rst_n),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .core_done  (core_done),
        .rd_data    (rd_data),
        .rd_idx     (rd_idx),
        .out_valid  (out_valid),
        .out_slot   (out_slot),
        .out_data   (out_data),
        .out_last   (out_last),
        .done       (done)
    );

endmodule

`default_nettype wire

// ==== tb/core_complex_chk.sv ====
// Output stream protocol checks

`timescale 1ns/1ps
`default_nettype none

module core_complex_chk (
    input wire logic core_clock,
    input wire logic rst_n,
    input wire logic out_valid,
    input wire logic out_last,
    input wire logic done
);

    int fail_count = 0;

    last_with_valid: assert property (@(posedge core_clock) disable iff (!rst_n)
        out_last |-> out_valid)
        else begin
            $error("out_last seen without out_valid");
            fail_count++;
        end

    done_apart: assert property (@(posedge core_clock) disable iff (!rst_n)
        !(done && out_valid))
        else begin
            $error("done and out_valid high in the same cycle");
            fail_count++;
        end

    // The final beat is followed directly by done
    done_after_last: assert property (@(posedge core_clock) disable iff (!rst_n)
        (out_valid && out_last) |=> done)
        else begin
            $error("done did not follow the final beat by one cycle");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge core_clock)
        !rst_n |=> (!done && !out_valid))
        else begin
            $error("done or out_valid high during reset");
            fail_count++;
        end

endmodule

bind core_complex core_complex_chk u_chk (
    .core_clock (core_clock),
    .rst_n      (rst_n),
    .out_valid  (out_valid),
    .out_last   (out_last),
    .done       (done)
);

`default_nettype wire

// ==== tb/core_complex_tb.sv ====
// Compute complex testbench

`timescale 1ns/1ps
`default_nettype none

`include "cx_macros.svh"

module core_complex_tb import cx_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;

    logic                          core_clock;
    logic                          rst_n;
    logic                          cfg_wr;
    logic [7:0]                    cfg_addr;
    word_t                         cfg_data;
    logic                          start;
    logic                          in_valid;
    reg_idx_t                      in_idx;
    word_t                         in_data;
    logic                          out_valid;
    logic [$clog2(`CX_N_SLOTS)-1:0] out_slot;
    word_t                         out_data;
    logic                          out_last;
    logic                          done;

    // Reference state mirrors the register file across all runs
    word_t       model_rf [`CX_REGS];
    logic [15:0] model_prog [`CX_PROG_DEPTH];
    reg_idx_t    model_slot [`CX_N_SLOTS];
    int          model_nslots;
    word_t       consts [`CX_N_CONSTANTS];
    word_t       sample_word;
    int          seed;
    int          errors;
    int          tests_run;
    int          tests_failed;

    core_complex u_dut (
        .core_clock (core_clock),
        .rst_n      (rst_n),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .start      (start),
        .in_valid   (in_valid),
        .in_idx     (in_idx),
        .in_data    (in_data),
        .out_valid  (out_valid),
        .out_slot   (out_slot),
        .out_data   (out_data),
        .out_last   (out_last),
        .done       (done)
    );

    initial begin
        core_clock = 1'b0;
        forever #4 core_clock = ~core_clock;
    end

    function automatic logic [15:0] encode_instr(cx_opcode_e op, int rd, int ra, int rb);
        return {op, 4'(rd), 4'(ra), 4'(rb)};
    endfunction

    // Executes the stored program on the model until a stop or the end of the store
    function automatic void run_model();
        int          pc;
        bit          stopped;
        logic [15:0] ins;
        reg_idx_t    rd;
        reg_idx_t    ra;
        reg_idx_t    rb;
        stopped = 1'b0;
        for (pc = 0; pc < `CX_PROG_DEPTH && !stopped; pc++) begin
            ins = model_prog[pc];
            rd  = ins[11:8];
            ra  = ins[7:4];
            rb  = ins[3:0];
            case (ins[15:12])
                OP_ADD:  model_rf[rd] = model_rf[ra] + model_rf[rb];
                OP_SUB:  model_rf[rd] = model_rf[ra] - model_rf[rb];
                OP_MUL:  model_rf[rd] = model_rf[ra] * model_rf[rb];
                OP_MOV:  model_rf[rd] = model_rf[ra];
                OP_STOP: stopped = 1'b1;
                default: ;
            endcase
        end
    endfunction

    function automatic void clear_program();
        int i;
        for (i = 0; i < `CX_PROG_DEPTH; i++)
            model_prog[i] = encode_instr(OP_STOP, 0, 0, 0);
    endfunction

    task automatic cfg_write(input logic [7:0] addr, input word_t data);
        @(negedge core_clock);
        cfg_wr   = 1'b1;
        cfg_addr = addr;
        cfg_data = data;
        @(negedge core_clock);
        cfg_wr = 1'b0;
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < `CX_PROG_DEPTH; i++)
            cfg_write({`CX_PROG_BASE, 6'(i)}, word_t'(model_prog[i]));
    endtask

    task automatic load_constants(input int n);
        int i;
        for (i = 0; i < `CX_N_CONSTANTS; i++)
            cfg_write({`CX_CONST_BASE, 6'(i)}, consts[i]);
        cfg_write({`CX_CONST_BASE, 6'h3F}, word_t'(n));
    endtask

    task automatic load_slots(input int n, input int s0, input int s1, input int s2,
                              input int s3);
        int i;
        model_slot[0] = reg_idx_t'(s0);
        model_slot[1] = reg_idx_t'(s1);
        model_slot[2] = reg_idx_t'(s2);
        model_slot[3] = reg_idx_t'(s3);
        model_nslots  = n;
        for (i = 0; i < `CX_N_SLOTS; i++)
            cfg_write({`CX_MOVER_BASE, 6'(i)}, word_t'(model_slot[i]));
        cfg_write({`CX_MOVER_BASE, 6'h3F}, word_t'(n));
    endtask

    task automatic send_sample(input int idx, input word_t data);
        @(negedge core_clock);
        in_valid = 1'b1;
        in_idx   = reg_idx_t'(idx);
        in_data  = data;
        @(negedge core_clock);
        in_valid = 1'b0;
        model_rf[idx] = data;
    endtask

    task automatic check_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED time=%0t %s expected=%h got=%h", $time, sig, expected, actual);
            errors++;
        end
    endtask

    task automatic check_beat(input int j);
        if (j >= model_nslots) begin
            $display("Output beat %0d arrived but only %0d slots are configured",
                     j, model_nslots);
            errors++;
        end else begin
            check_value("out_slot", 32'(j), 32'(out_slot));
            check_value("out_data", model_rf[model_slot[j]], out_data);
            check_value("out_last", 32'(j == model_nslots - 1), 32'(out_last));
        end
    endtask

    // One start, an optional sample that collides with the first constant beat, then the outputs
    task automatic run_test(input string name, input int n_act, input bit collide);
        int i;
        int beats;
        int cycles;
        int errs_at_start;
        bit got_done;
        errs_at_start = errors;
        beats         = 0;
        cycles        = 0;
        got_done      = 1'b0;
        for (i = 0; i < n_act; i++)
            model_rf[i] = consts[i];
        if (collide)
            model_rf[8] = sample_word;
        run_model();
        @(negedge core_clock);
        start = 1'b1;
        @(negedge core_clock);
        start = 1'b0;
        if (collide) begin
            in_valid = 1'b1;
            in_idx   = reg_idx_t'(8);
            in_data  = sample_word;
            @(negedge core_clock);
            in_valid = 1'b0;
        end
        while (!got_done && cycles < TIMEOUT_CYCLES) begin
            @(negedge core_clock);
            cycles++;
            if (out_valid) begin
                check_beat(beats);
                beats++;
            end
            if (done)
                got_done = 1'b1;
        end
        if (!got_done) begin
            $display("Timeout in test %s, done never arrived", name);
            errors++;
        end else if (beats != model_nslots) begin
            $display("Test %s gave %0d output beats where %0d were expected",
                     name, beats, model_nslots);
            errors++;
        end
        tests_run++;
        if (errors != errs_at_start)
            tests_failed++;
        $display("Test %-12s %s", name, (errors == errs_at_start) ? "ok" : "failed");
    endtask

    initial begin
        int i;
        rst_n        = 1'b0;
        cfg_wr       = 1'b0;
        cfg_addr     = '0;
        cfg_data     = '0;
        start        = 1'b0;
        in_valid     = 1'b0;
        in_idx       = '0;
        in_data      = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_nslots = 0;
        seed         = 99531;
        repeat (16) @(negedge core_clock);
        rst_n = 1'b1;

        for (i = 0; i < `CX_N_CONSTANTS; i++)
            consts[i] = $random(seed);

        clear_program();
        model_prog[0] = encode_instr(OP_ADD, 4, 0, 1);
        model_prog[1] = encode_instr(OP_SUB, 5, 2, 3);
        model_prog[2] = encode_instr(OP_MUL, 6, 0, 3);
        load_program();
        load_constants(4);
        load_slots(4, 4, 5, 6, 2);
        run_test("arith", 4, 1'b0);

        send_sample(9, $random(seed));
        sample_word = $random(seed);
        clear_program();
        model_prog[0] = encode_instr(OP_MOV, 10, 9, 0);
        model_prog[1] = encode_instr(OP_MOV, 11, 8, 0);
        model_prog[2] = encode_instr(OP_ADD, 12, 8, 9);
        load_program();
        load_constants(2);
        load_slots(3, 10, 11, 12, 0);
        run_test("samples", 2, 1'b1);

        clear_program();
        model_prog[0] = encode_instr(OP_ADD, 13, 4, 5);
        load_program();
        load_constants(0);
        load_slots(1, 13, 0, 0, 0);
        run_test("zero_const", 0, 1'b0);

        load_constants(4);
        load_slots(0, 0, 0, 0, 0);
        run_test("zero_slots", 4, 1'b0);

        // The SUB after the stop must leave r14 alone
        clear_program();
        model_prog[0] = encode_instr(OP_ADD, 14, 0, 1);
        model_prog[2] = encode_instr(OP_SUB, 14, 2, 3);
        load_program();
        load_slots(1, 14, 0, 0, 0);
        run_test("early_stop", 4, 1'b0);

        model_prog[0] = encode_instr(OP_MOV, 7, 1, 0);
        for (i = 1; i < `CX_PROG_DEPTH; i++)
            model_prog[i] = encode_instr(OP_ADD, 7, 7, 0);
        load_program();
        load_slots(1, 7, 0, 0, 0);
        run_test("no_stop", 4, 1'b0);

        clear_program();
        load_program();
        load_slots(4, 0, 1, 2, 3);
        run_test("framing", 4, 1'b0);

        errors = errors + u_dut.u_chk.fail_count;
        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+hdl
hdl/cx_pkg.sv
hdl/cx_write_if.sv
hdl/constant_injector.sv
hdl/write_merger.sv
hdl/program_core.sv
hdl/result_mover.sv
hdl/core_complex.sv
tb/core_complex_chk.sv
tb/core_complex_tb.sv

// ==== Makefile ====
# Verilator build for the compute complex testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = core_complex_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -F -q "*** PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
